//--- verilog/video_bus_pkg.sv
`default_nettype none

package video_bus_pkg;

    ////////////////////////////////////////////////////////////////////////////
    // Register bus
    ////////////////////////////////////////////////////////////////////////////
    localparam int REGBUS_ADDR_W = 18;
    localparam int DATA_W        = 8;

    ////////////////////////////////////////////////////////////////////////////
    // Main RAM, 4 KB mirrored through 00000-1FFFF
    ////////////////////////////////////////////////////////////////////////////
    localparam int MAINRAM_WORD_W     = 32;
    localparam int MAINRAM_WORDS      = 1024;
    localparam int MAINRAM_ADDR_W     = 10;
    localparam int MAINRAM_LANES      = MAINRAM_WORD_W / DATA_W;
    localparam int MAINRAM_LANE_W     = 2;
    localparam int MAINRAM_REGION_BIT = 17;

    ////////////////////////////////////////////////////////////////////////////
    // Palette, 20000-201FF
    ////////////////////////////////////////////////////////////////////////////
    localparam int PALETTE_ENTRIES = 256;
    localparam int PALETTE_ENTRY_W = 16;
    localparam int PALETTE_IDX_W   = 8;
    localparam int RGB_W           = 12;

    // Bits above the entry index and byte select identify the palette region
    localparam int PALETTE_DECODE_LSB = PALETTE_IDX_W + 1;

    localparam logic [REGBUS_ADDR_W-1:0] PALETTE_BASE = 18'h20000;

    // Block reached by a register bus access
    typedef enum logic [1:0] {
        TARGET_NONE     = 2'd0,
        TARGET_MAIN_RAM = 2'd1,
        TARGET_PALETTE  = 2'd2
    } bus_target_e;

endpackage

`default_nettype wire

//--- verilog/regbus_if.sv
`timescale 1ns/1ps
`default_nettype none

// One byte access from the decoder to a storage block
interface regbus_if
    import video_bus_pkg::*;
();

    logic [REGBUS_ADDR_W-1:0] addr;
    logic [DATA_W-1:0]        wrdata;
    logic                     write;
    logic                     strobe;
    logic [DATA_W-1:0]        rddata;

    modport decoder (
        output addr,
        output wrdata,
        output write,
        output strobe,
        input  rddata
    );

    modport storage (
        input  addr,
        input  wrdata,
        input  write,
        input  strobe,
        output rddata
    );

endinterface

`default_nettype wire

//--- verilog/main_ram_port.sv
`timescale 1ns/1ps
`default_nettype none

module main_ram_port
    import video_bus_pkg::*;
(
    input  logic      clk,
    regbus_if.storage bus
);

    logic [MAINRAM_WORD_W-1:0] mem [MAINRAM_WORDS];

    logic [MAINRAM_ADDR_W-1:0] word_addr;
    logic [MAINRAM_LANE_W-1:0] lane;
    logic [MAINRAM_LANES-1:0]  byte_en;
    logic [MAINRAM_WORD_W-1:0] wr_word;

    logic [MAINRAM_WORD_W-1:0] rd_word_r;
    logic [MAINRAM_LANE_W-1:0] rd_lane_r;

    // Only the low 12 address bits count, so the RAM mirrors across its region
    assign word_addr = bus.addr[MAINRAM_ADDR_W+MAINRAM_LANE_W-1:MAINRAM_LANE_W];
    assign lane      = bus.addr[MAINRAM_LANE_W-1:0];

    // Same byte on every lane, enable picks the one that lands
    assign wr_word = {MAINRAM_LANES{bus.wrdata}};

    always_comb begin
        byte_en       = '0;
        byte_en[lane] = 1'b1;
    end

    ////////////////////////////////////////////////////////////////////////////
    // Storage
    ////////////////////////////////////////////////////////////////////////////
    always_ff @(posedge clk) begin
        if (bus.strobe && bus.write) begin
            for (int i = 0; i < MAINRAM_LANES; i++) begin
                if (byte_en[i]) begin
                    mem[word_addr][i*DATA_W +: DATA_W] <= wr_word[i*DATA_W +: DATA_W];
                end
            end
        end
    end

    // Read word and lane captured at the read strobe
    always_ff @(posedge clk) begin
        if (bus.strobe && !bus.write) begin
            rd_word_r <= mem[word_addr];
            rd_lane_r <= lane;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Byte extraction
    ////////////////////////////////////////////////////////////////////////////
    always_comb begin
        case (rd_lane_r)
            2'd0:    bus.rddata = rd_word_r[7:0];
            2'd1:    bus.rddata = rd_word_r[15:8];
            2'd2:    bus.rddata = rd_word_r[23:16];
            default: bus.rddata = rd_word_r[31:24];
        endcase
    end

endmodule

`default_nettype wire

//--- verilog/palette_ram.sv
`timescale 1ns/1ps
`default_nettype none

module palette_ram
    import video_bus_pkg::*;
(
    input  logic               clk,
    regbus_if.storage          bus,
    input  logic [DATA_W-1:0]  pixel_index_i,
    output logic [RGB_W-1:0]   rgb_o
);

    logic [PALETTE_ENTRY_W-1:0] mem [PALETTE_ENTRIES];

    logic [PALETTE_IDX_W-1:0]   entry_idx;
    logic                       high_byte;

    logic [PALETTE_ENTRY_W-1:0] bus_entry_r;
    logic                       bus_high_r;
    logic [PALETTE_ENTRY_W-1:0] pix_entry_r;

    // Odd address is the high byte of an entry
    assign entry_idx = bus.addr[PALETTE_IDX_W:1];
    assign high_byte = bus.addr[0];

    ////////////////////////////////////////////////////////////////////////////
    // Bus side
    ////////////////////////////////////////////////////////////////////////////
    always_ff @(posedge clk) begin
        if (bus.strobe && bus.write) begin
            if (high_byte) begin
                mem[entry_idx][PALETTE_ENTRY_W-1:DATA_W] <= bus.wrdata;
            end else begin
                mem[entry_idx][DATA_W-1:0] <= bus.wrdata;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (bus.strobe && !bus.write) begin
            bus_entry_r <= mem[entry_idx];
            bus_high_r  <= high_byte;
        end
    end

    assign bus.rddata = bus_high_r ? bus_entry_r[PALETTE_ENTRY_W-1:DATA_W]
                                   : bus_entry_r[DATA_W-1:0];

    ////////////////////////////////////////////////////////////////////////////
    // Pixel lookup port
    ////////////////////////////////////////////////////////////////////////////
    // Free running, one cycle from index to colour
    always_ff @(posedge clk) begin
        pix_entry_r <= mem[pixel_index_i];
    end

    // Red 11:8, green 7:4, blue 3:0
    assign rgb_o = pix_entry_r[RGB_W-1:0];

endmodule

`default_nettype wire

//--- verilog/regbus_decoder.sv
`timescale 1ns/1ps
`default_nettype none

module regbus_decoder
    import video_bus_pkg::*;
(
    input  logic                     reset,
    input  logic                     clk,
    input  logic [REGBUS_ADDR_W-1:0] addr_i,
    input  logic [DATA_W-1:0]        wrdata_i,
    input  logic                     write_i,
    input  logic                     strobe_i,
    output logic [DATA_W-1:0]        rddata_o,
    regbus_if.decoder                ram_bus,
    regbus_if.decoder                pal_bus
);

    bus_target_e target;
    bus_target_e target_r;

    ////////////////////////////////////////////////////////////////////////////
    // Address decode
    ////////////////////////////////////////////////////////////////////////////
    // 00000-1FFFF  Main RAM (4 KB, mirrored)
    // 20000-201FF  Palette
    // Anything else reads as 00 and ignores writes
    always_comb begin
        if (!addr_i[MAINRAM_REGION_BIT]) begin
            target = TARGET_MAIN_RAM;
        end else if (addr_i[REGBUS_ADDR_W-1:PALETTE_DECODE_LSB] ==
                     PALETTE_BASE[REGBUS_ADDR_W-1:PALETTE_DECODE_LSB]) begin
            target = TARGET_PALETTE;
        end else begin
            target = TARGET_NONE;
        end
    end

    // Both blocks see every access, only the strobe is steered
    assign ram_bus.addr   = addr_i;
    assign ram_bus.wrdata = wrdata_i;
    assign ram_bus.write  = write_i;
    assign ram_bus.strobe = strobe_i && (target == TARGET_MAIN_RAM);

    assign pal_bus.addr   = addr_i;
    assign pal_bus.wrdata = wrdata_i;
    assign pal_bus.write  = write_i;
    assign pal_bus.strobe = strobe_i && (target == TARGET_PALETTE);

    ////////////////////////////////////////////////////////////////////////////
    // Read data combiner
    ////////////////////////////////////////////////////////////////////////////
    // Selection follows the read by one cycle, like the storage blocks
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            target_r <= TARGET_NONE;
        end else begin
            if (strobe_i && !write_i) begin
                target_r <= target;
            end
        end
    end

    always_comb begin
        case (target_r)
            TARGET_MAIN_RAM: rddata_o = ram_bus.rddata;
            TARGET_PALETTE:  rddata_o = pal_bus.rddata;
            default:         rddata_o = '0;
        endcase
    end

endmodule

`default_nettype wire

//--- verilog/video_bus_top.sv
`timescale 1ns/1ps
`default_nettype none

module video_bus_top
    import video_bus_pkg::*;
(
    input  logic                     reset,
    input  logic                     clk,

    // Register bus
    input  logic [REGBUS_ADDR_W-1:0] regbus_addr_i,
    input  logic [DATA_W-1:0]        regbus_wrdata_i,
    input  logic                     regbus_write_i,
    input  logic                     regbus_strobe_i,
    output logic [DATA_W-1:0]        regbus_rddata_o,

    // Pixel lookup
    input  logic [DATA_W-1:0]        pixel_index_i,
    output logic [RGB_W-1:0]         rgb_o
);

    regbus_if ram_bus();
    regbus_if pal_bus();

    ////////////////////////////////////////////////////////////////////////////
    // Decoder
    ////////////////////////////////////////////////////////////////////////////
    regbus_decoder decoder (
        .reset    (reset),
        .clk      (clk),
        .addr_i   (regbus_addr_i),
        .wrdata_i (regbus_wrdata_i),
        .write_i  (regbus_write_i),
        .strobe_i (regbus_strobe_i),
        .rddata_o (regbus_rddata_o),
        .ram_bus  (ram_bus.decoder),
        .pal_bus  (pal_bus.decoder)
    );

    ////////////////////////////////////////////////////////////////////////////
    // Storage
    ////////////////////////////////////////////////////////////////////////////
    main_ram_port main_ram (
        .clk (clk),
        .bus (ram_bus.storage)
    );

    palette_ram palette (
        .clk           (clk),
        .bus           (pal_bus.storage),
        .pixel_index_i (pixel_index_i),
        .rgb_o         (rgb_o)
    );

endmodule

`default_nettype wire

//--- verification/video_bus_tb.sv
`timescale 1ns/1ps
`default_nettype none

module video_bus_tb
    import video_bus_pkg::*;
();

    typedef enum logic [1:0] {
        OP_IDLE,
        OP_WRITE,
        OP_READ,
        OP_PIXEL
    } op_e;

    localparam int MAX_ROWS     = 128;
    localparam int RESET_CYCLES = 16;

    logic                     clk;
    logic                     reset;
    logic [REGBUS_ADDR_W-1:0] regbus_addr_i;
    logic [DATA_W-1:0]        regbus_wrdata_i;
    logic                     regbus_write_i;
    logic                     regbus_strobe_i;
    logic [DATA_W-1:0]        regbus_rddata_o;
    logic [DATA_W-1:0]        pixel_index_i;
    logic [RGB_W-1:0]         rgb_o;

    // Stimulus table, one row per cycle
    op_e                      op_tab   [MAX_ROWS];
    logic [REGBUS_ADDR_W-1:0] addr_tab [MAX_ROWS];
    logic [DATA_W-1:0]        data_tab [MAX_ROWS];
    logic [15:0]              exp_tab  [MAX_ROWS];
    int                       num_rows;
    bit                       table_ready = 1'b0;

    // Reference contents of both storage blocks
    logic [DATA_W-1:0]          ram_model [4096];
    logic [PALETTE_ENTRY_W-1:0] pal_model [PALETTE_ENTRIES];
    logic [DATA_W-1:0]          last_rd;

    integer seed;
    int     pass_count;
    int     fail_count;

    video_bus_top uut (
        .reset           (reset),
        .clk             (clk),
        .regbus_addr_i   (regbus_addr_i),
        .regbus_wrdata_i (regbus_wrdata_i),
        .regbus_write_i  (regbus_write_i),
        .regbus_strobe_i (regbus_strobe_i),
        .regbus_rddata_o (regbus_rddata_o),
        .pixel_index_i   (pixel_index_i),
        .rgb_o           (rgb_o)
    );

    always #50 clk = ~clk;

    ////////////////////////////////////////////////////////////////////////////
    // Reference model and table building
    ////////////////////////////////////////////////////////////////////////////
    function automatic logic [DATA_W-1:0] model_byte(input logic [REGBUS_ADDR_W-1:0] addr);
        logic [PALETTE_ENTRY_W-1:0] entry;
        entry = pal_model[addr[8:1]];
        if (addr < 18'h20000) begin
            return ram_model[addr % 4096];
        end else if (addr < 18'h20200) begin
            return addr[0] ? entry[15:8] : entry[7:0];
        end
        // Unmapped
        return 8'h00;
    endfunction

    function automatic logic [DATA_W-1:0] rand_byte();
        integer r;
        r = $random(seed);
        return r[DATA_W-1:0];
    endfunction

    function automatic string op_name(input op_e op);
        case (op)
            OP_WRITE: return "write";
            OP_READ:  return "read ";
            OP_PIXEL: return "pixel";
            default:  return "idle ";
        endcase
    endfunction

    task automatic write_row(input logic [REGBUS_ADDR_W-1:0] addr, input logic [DATA_W-1:0] data);
        op_tab[num_rows]   = OP_WRITE;
        addr_tab[num_rows] = addr;
        data_tab[num_rows] = data;
        exp_tab[num_rows]  = {8'h00, last_rd};
        num_rows++;
        if (addr < 18'h20000) begin
            ram_model[addr % 4096] = data;
        end else if (addr < 18'h20200) begin
            if (addr[0]) begin
                pal_model[addr[8:1]][15:8] = data;
            end else begin
                pal_model[addr[8:1]][7:0] = data;
            end
        end
    endtask

    task automatic read_row(input logic [REGBUS_ADDR_W-1:0] addr);
        last_rd            = model_byte(addr);
        op_tab[num_rows]   = OP_READ;
        addr_tab[num_rows] = addr;
        data_tab[num_rows] = 8'h00;
        exp_tab[num_rows]  = {8'h00, last_rd};
        num_rows++;
    endtask

    task automatic lookup_row(input logic [DATA_W-1:0] idx);
        op_tab[num_rows]   = OP_PIXEL;
        addr_tab[num_rows] = {10'h000, idx};
        data_tab[num_rows] = 8'h00;
        exp_tab[num_rows]  = {4'h0, pal_model[idx][RGB_W-1:0]};
        num_rows++;
    endtask

    task automatic idle_row();
        op_tab[num_rows]   = OP_IDLE;
        addr_tab[num_rows] = '0;
        data_tab[num_rows] = 8'h00;
        exp_tab[num_rows]  = {8'h00, last_rd};
        num_rows++;
    endtask

    task automatic build_table();
        logic [REGBUS_ADDR_W-1:0] base;
        num_rows = 0;
        last_rd  = 8'h00;
        // Read path is 00 straight after reset
        idle_row();
        // Four lanes of the words at 000, 554, AA8 and FFC read back on consecutive cycles
        for (int w = 0; w < 4; w++) begin
            for (int b = 0; b < 4; b++) begin
                base = w * 18'h554;
                write_row(base + b, rand_byte());
            end
        end
        for (int a = 0; a < 16; a++) begin
            read_row((a / 4) * 18'h554 + (a % 4));
        end
        // Lane 2 only so the neighbouring lanes must survive
        write_row(18'h00556, rand_byte());
        for (int b = 0; b < 4; b++) begin
            read_row(18'h00554 + b);
        end
        // Mirrors of the 4 KB
        read_row(18'h01000);
        read_row(18'h10555);
        read_row(18'h01FFF);
        read_row(18'h10AA9);
        read_row(18'h1F556);
        idle_row();
        idle_row();
        // Palette entries 00, 33, 66, 99, CC, FF
        for (int k = 0; k < 12; k++) begin
            write_row(18'h20000 + (k / 2) * 18'h66 + (k % 2), rand_byte());
        end
        for (int k = 0; k < 12; k++) begin
            read_row(18'h20000 + (k / 2) * 18'h66 + (k % 2));
        end
        for (int k = 0; k < 6; k++) begin
            lookup_row(k * 8'h33);
        end
        // Unmapped writes must not land anywhere
        write_row(18'h30000, rand_byte());
        write_row(18'h20200, rand_byte());
        write_row(18'h3FFFF, rand_byte());
        // Bytes that a decoder using only the low address bits would overwrite
        read_row(18'h00000);
        read_row(18'h00FFF);
        read_row(18'h20000);
        read_row(18'h201FF);
        lookup_row(8'h00);
        read_row(18'h30000);
        read_row(18'h20200);
        idle_row();
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Drive and check
    ////////////////////////////////////////////////////////////////////////////
    task automatic apply_row(input int i);
        regbus_addr_i   = addr_tab[i];
        regbus_wrdata_i = data_tab[i];
        regbus_write_i  = 1'b0;
        regbus_strobe_i = 1'b0;
        case (op_tab[i])
            OP_WRITE: begin
                regbus_write_i  = 1'b1;
                regbus_strobe_i = 1'b1;
            end
            OP_READ:  regbus_strobe_i = 1'b1;
            OP_PIXEL: pixel_index_i = addr_tab[i][DATA_W-1:0];
            default:  regbus_strobe_i = 1'b0;
        endcase
    endtask

    task automatic check_row(input int i);
        string       sig;
        logic [15:0] actual;
        if (op_tab[i] == OP_PIXEL) begin
            sig    = "rgb_o";
            actual = {4'h0, rgb_o};
        end else begin
            // Writes and idle cycles must leave the last read byte in place
            sig    = "regbus_rddata_o";
            actual = {8'h00, regbus_rddata_o};
        end
        if (actual !== exp_tab[i]) begin
            $display("FAILED at %0t ns: row %0d %s addr %05h, %s expected %0h, actual %0h",
                     $time, i, op_name(op_tab[i]), addr_tab[i], sig, exp_tab[i], actual);
            fail_count++;
        end else begin
            $display("ok     row %0d %s addr %05h, %s = %0h",
                     i, op_name(op_tab[i]), addr_tab[i], sig, actual);
            pass_count++;
        end
    endtask

    initial begin
        clk             = 1'b0;
        reset           = 1'b1;
        regbus_addr_i   = '0;
        regbus_wrdata_i = '0;
        regbus_write_i  = 1'b0;
        regbus_strobe_i = 1'b0;
        pixel_index_i   = '0;
        seed            = 10;
        pass_count      = 0;
        fail_count      = 0;
        build_table();
        table_ready = 1'b1;

        repeat (RESET_CYCLES) @(posedge clk);
        #5;
        reset = 1'b0;

        for (int i = 0; i < num_rows; i++) begin
            apply_row(i);
            @(posedge clk);
            #5;
            check_row(i);
        end
        regbus_strobe_i = 1'b0;
        regbus_write_i  = 1'b0;

        $display("Tests run: %0d, passed: %0d, failed: %0d",
                 pass_count + fail_count, pass_count, fail_count);
        if (fail_count == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

    // Watchdog sized from the table length
    initial begin
        wait (table_ready);
        #((RESET_CYCLES + 3 * num_rows + 20) * 100);
        $display("Watchdog timeout: the test sequence did not finish in time");
        $display("Simulation FAILED");
        $finish;
    end

endmodule

`default_nettype wire

//--- all.f
verilog/video_bus_pkg.sv
verilog/regbus_if.sv
verilog/main_ram_port.sv
verilog/palette_ram.sv
verilog/regbus_decoder.sv
verilog/video_bus_top.sv
verification/video_bus_tb.sv
